// File: verilog.f
source/sniffer_cfg_pkg.sv
source/dram_cmd_pkg.sv
source/dram_port_if.sv
source/ctrl_opb_attach.sv
source/mem_opb_attach.sv
source/dram_arbiter.sv
source/opb_dram_sniffer.sv
verif/tb_clock_gen.sv
verif/opb_dram_sniffer_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module opb_dram_sniffer_tb \
  -f verilog.f -o opb_dram_sniffer_sim \
  && ./obj_dir/opb_dram_sniffer_sim > sim.log 2>&1 \
  || echo "Build or simulation did not complete" >> sim.log
cat sim.log
grep -q "^Simulation PASSED$" sim.log && exit 0 || exit 1

// File: verif/opb_dram_sniffer_tb.sv
module opb_dram_sniffer_tb
  import sniffer_cfg_pkg::*;
  import dram_cmd_pkg::*;
();

  localparam logic [31:0] CTRL_BASE = 32'h8000_0000;
  localparam logic [31:0] MEM_BASE  = 32'h9000_0000;
  localparam logic [31:0] APP_BASE  = 32'h0440_0000;  // DRAM bytes 0x1100_xxxx.
  localparam int          TIMEOUT   = 200;
  localparam int          WATCHDOG  = 100000;

  logic         clk;
  logic         rst_n;
  logic         phy_ready;
  logic [31:0]  ctrl_opb_abus;
  logic [3:0]   ctrl_opb_be;
  logic [31:0]  ctrl_opb_dbus;
  logic         ctrl_opb_rnw;
  logic         ctrl_opb_select;
  logic [31:0]  ctrl_sl_dbus;
  logic         ctrl_sl_xferack;
  logic         ctrl_sl_errack;
  logic [31:0]  mem_opb_abus;
  logic [3:0]   mem_opb_be;
  logic [31:0]  mem_opb_dbus;
  logic         mem_opb_rnw;
  logic         mem_opb_select;
  logic [31:0]  mem_sl_dbus;
  logic         mem_sl_xferack;
  logic [31:0]  dram_cmd_addr;
  logic         dram_cmd_rnw;
  logic         dram_cmd_valid;
  logic [127:0] dram_wr_data;
  logic [15:0]  dram_wr_be;
  logic [127:0] dram_rd_data = '0;
  logic         dram_rd_valid = 1'b0;
  logic         dram_fifo_ready = 1'b0;
  logic [31:0]  app_cmd_addr;
  logic         app_cmd_rnw;
  logic         app_cmd_valid;
  logic         app_cmd_ack;
  logic [127:0] app_wr_data;
  logic [15:0]  app_wr_be;
  logic [127:0] app_rd_data;
  logic         app_rd_valid;

  logic [127:0] dram_mem [logic [31:0]];
  logic [127:0] ref_mem [logic [31:0]];
  logic [127:0] ret_data_q [$];
  longint       ret_due_q [$];
  logic [127:0] app_exp_q [$];  // App read data in issue order.
  longint       cyc = 0;
  longint       last_due = 0;
  logic [15:0]  sw_val = '0;
  int           mismatch_cnt = 0;
  int           fail_cnt = 0;

  tb_clock_gen #(.PERIOD(10)) clk_gen_i (.clk(clk));

  opb_dram_sniffer dut_i (.*);

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  function automatic logic [127:0] dram_word(input logic [31:0] a);
    return dram_mem.exists(a) ? dram_mem[a] : 128'h0;
  endfunction

  function automatic logic [127:0] ref_word(input logic [31:0] a);
    return ref_mem.exists(a) ? ref_mem[a] : 128'h0;
  endfunction

  function automatic logic [127:0] merge_be(input logic [127:0] old, input logic [127:0] data,
                                            input logic [15:0] be);
    logic [127:0] res;
    res = old;
    for (int b = 0; b < 16; b++) begin
      if (be[b]) begin
        res[b*8 +: 8] = data[b*8 +: 8];
      end
    end
    return res;
  endfunction

  task automatic check_eq(input string name, input logic [127:0] exp, input logic [127:0] act);
    assert (act === exp) else begin
      mismatch_cnt++;
      $display("MISMATCH at %0t: %s expected %0h, got %0h", $time, name, exp, act);
    end
  endtask

  task automatic report_fail(input string msg);
    fail_cnt++;
    $display("ERROR at %0t: %s", $time, msg);
  endtask

  //////////////////////////////////////////////////
  // DRAM model
  //////////////////////////////////////////////////

  // Commands are seen at the falling edge, as the DUT sees them at the next rise.
  always @(negedge clk) begin : dram_accept
    longint due;
    if (rst_n && dram_cmd_valid && dram_fifo_ready) begin
      if (dram_cmd_rnw) begin
        due = cyc + 3 + longint'($urandom_range(4));
        if (due <= last_due) begin
          due = last_due + 1;  // Keep returns in order.
        end
        last_due = due;
        ret_due_q.push_back(due);
        ret_data_q.push_back(dram_word(dram_cmd_addr));
      end else begin
        dram_mem[dram_cmd_addr] = merge_be(dram_word(dram_cmd_addr), dram_wr_data, dram_wr_be);
      end
    end
  end

  always @(posedge clk) begin : dram_return
    cyc++;
    dram_fifo_ready <= ($urandom_range(9) < 7);
    dram_rd_valid   <= 1'b0;
    dram_rd_data    <= '0;
    if (ret_due_q.size() > 0 && ret_due_q[0] <= cyc) begin
      void'(ret_due_q.pop_front());
      dram_rd_valid <= 1'b1;
      dram_rd_data  <= ret_data_q.pop_front();
    end
  end

  always @(negedge clk) begin : app_monitor
    if (rst_n && app_cmd_ack) begin
      assert (dram_fifo_ready && dram_cmd_valid && app_cmd_valid) else
        report_fail("app_cmd_ack high without a forwarded app command");
    end
    if (rst_n && app_rd_valid) begin
      assert (app_exp_q.size() != 0) else report_fail("app_rd_valid with no app read in flight");
      if (app_exp_q.size() != 0) begin
        check_eq("app_rd_data", app_exp_q.pop_front(), app_rd_data);
      end
    end
  end

  //////////////////////////////////////////////////
  // Bus tasks
  //////////////////////////////////////////////////

  task automatic ctrl_access(input logic rnw, input logic [31:0] off, input logic [31:0] wdata,
                             output logic [31:0] rdata, output logic err);
    int n;
    n = 0;
    @(posedge clk);
    ctrl_opb_abus   <= CTRL_BASE + off;
    ctrl_opb_be     <= 4'hF;
    ctrl_opb_dbus   <= wdata;
    ctrl_opb_rnw    <= rnw;
    ctrl_opb_select <= 1'b1;
    do begin
      @(negedge clk);
      n++;
    end while (!ctrl_sl_xferack && !ctrl_sl_errack && n < TIMEOUT);
    assert (ctrl_sl_xferack || ctrl_sl_errack) else report_fail("control slave never answered");
    rdata = ctrl_sl_dbus;
    err   = ctrl_sl_errack && !ctrl_sl_xferack;
    @(posedge clk);
    ctrl_opb_select <= 1'b0;
  endtask

  task automatic win_access(input logic rnw, input logic [31:0] off, input logic [31:0] wdata,
                            input logic [3:0] be, input bit chk_cmd);
    int           n;
    logic [31:0]  key;
    logic [1:0]   lane;
    logic [127:0] word;
    key  = {sw_val[7:0], off[25:4], 2'b00};
    lane = off[3:2];
    word = ref_word(key);
    if (!rnw) begin
      ref_mem[key] = merge_be(word, 128'(wdata) << (lane * 32), 16'(be) << (lane * 4));
    end
    n = 0;
    @(posedge clk);
    mem_opb_abus   <= MEM_BASE + off;
    mem_opb_be     <= be;
    mem_opb_dbus   <= wdata;
    mem_opb_rnw    <= rnw;
    mem_opb_select <= 1'b1;
    do begin
      @(negedge clk);
      n++;
      if (chk_cmd && dram_cmd_valid && dram_fifo_ready) begin
        check_eq("dram_cmd_addr", key, dram_cmd_addr);
        check_eq("dram_cmd_rnw", rnw, dram_cmd_rnw);
        if (!rnw) begin
          check_eq("dram_wr_be", 16'(be) << (lane * 4), dram_wr_be);
        end
      end
    end while (!mem_sl_xferack && n < TIMEOUT);
    assert (mem_sl_xferack) else report_fail("memory window slave never acknowledged");
    if (rnw && mem_sl_xferack) begin
      check_eq("mem_sl_dbus", word[lane*32 +: 32], mem_sl_dbus);
    end
    @(posedge clk);
    mem_opb_select <= 1'b0;
  endtask

  task automatic app_cmd(input logic rnw, input logic [31:0] addr, input logic [127:0] wdata,
                         input logic [15:0] be);
    int          n;
    logic [31:0] key;
    key = addr << 2;
    n   = 0;
    @(posedge clk);
    app_cmd_addr  <= addr;
    app_cmd_rnw   <= rnw;
    app_wr_data   <= wdata;
    app_wr_be     <= be;
    app_cmd_valid <= 1'b1;
    do begin
      @(negedge clk);
      n++;
    end while (!app_cmd_ack && n < TIMEOUT);
    assert (app_cmd_ack) else report_fail("application command was never acknowledged");
    if (app_cmd_ack) begin
      check_eq("dram_cmd_addr", key, dram_cmd_addr);
      check_eq("dram_cmd_rnw", rnw, dram_cmd_rnw);
      if (rnw) begin
        app_exp_q.push_back(ref_word(key));
      end else begin
        check_eq("dram_wr_data", wdata, dram_wr_data);
        ref_mem[key] = merge_be(ref_word(key), wdata, be);
      end
    end
    @(posedge clk);
    app_cmd_valid <= 1'b0;
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    logic [31:0] rdata;
    logic        err;
    logic        phy;
    logic [15:0] val;
    logic [31:0] offs [8];
    int          n;
    void'($urandom(7));
    rst_n           <= 1'b0;
    phy_ready       <= 1'b0;
    ctrl_opb_abus   <= '0;
    ctrl_opb_be     <= '0;
    ctrl_opb_dbus   <= '0;
    ctrl_opb_rnw    <= 1'b0;
    ctrl_opb_select <= 1'b0;
    mem_opb_abus    <= '0;
    mem_opb_be      <= '0;
    mem_opb_dbus    <= '0;
    mem_opb_rnw     <= 1'b0;
    mem_opb_select  <= 1'b0;
    app_cmd_addr    <= '0;
    app_cmd_rnw     <= 1'b0;
    app_cmd_valid   <= 1'b0;
    app_wr_data     <= '0;
    app_wr_be       <= '0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_eq("ctrl_sl_xferack", 0, ctrl_sl_xferack);
    check_eq("mem_sl_xferack", 0, mem_sl_xferack);
    check_eq("dram_cmd_valid", 0, dram_cmd_valid);
    check_eq("app_cmd_ack", 0, app_cmd_ack);
    check_eq("app_rd_valid", 0, app_rd_valid);
    ctrl_access(1'b1, CTRL_REG_SWADDR, '0, rdata, err);
    check_eq("ctrl_sl_errack", 0, err);
    check_eq("ctrl_sl_dbus", 0, rdata);

    // Control registers.
    val = 16'($urandom);
    ctrl_access(1'b0, CTRL_REG_SWADDR, {16'h0, val}, rdata, err);
    ctrl_access(1'b1, CTRL_REG_SWADDR, '0, rdata, err);
    check_eq("ctrl_sl_dbus", {16'h0, val}, rdata);
    phy = 1'($urandom_range(1));
    for (int i = 0; i < 2; i++) begin
      phy_ready <= phy;
      ctrl_access(1'b1, CTRL_REG_STATUS, '0, rdata, err);
      check_eq("ctrl_sl_errack", 0, err);
      check_eq("ctrl_sl_dbus", {31'h0, phy}, rdata);
      phy = !phy;  // Both levels of the flag.
    end
    ctrl_access(1'b1, 32'h8, '0, rdata, err);
    check_eq("ctrl_sl_errack", 1, err);

    // Window writes then read back; bit 7 keeps it clear of the app region.
    sw_val = 16'($urandom) | 16'h0080;
    ctrl_access(1'b0, CTRL_REG_SWADDR, {16'h0, sw_val}, rdata, err);
    for (int i = 0; i < 8; i++) begin
      offs[i] = 32'($urandom_range(63)) << 2;
      win_access(1'b0, offs[i], $urandom, 4'($urandom_range(15, 1)), 1'b1);
    end
    for (int i = 0; i < 8; i++) begin
      win_access(1'b1, offs[i], '0, 4'hF, 1'b1);
    end

    for (int i = 0; i < 16; i++) begin
      app_cmd($urandom_range(1) == 1, APP_BASE + $urandom_range(7),
              {$urandom, $urandom, $urandom, $urandom}, 16'($urandom));
    end

    fork
      begin
        for (int i = 0; i < 40; i++) begin
          app_cmd($urandom_range(1) == 1, APP_BASE + $urandom_range(15),
                  {$urandom, $urandom, $urandom, $urandom}, 16'($urandom));
        end
      end
      begin
        for (int i = 0; i < 20; i++) begin
          win_access($urandom_range(1) == 1, 32'($urandom_range(63)) << 2, $urandom,
                     4'($urandom_range(15, 1)), 1'b0);
        end
      end
    join

    n = 0;
    while (app_exp_q.size() > 0 && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    assert (app_exp_q.size() == 0) else report_fail("app reads still outstanding at the end");

    $display("Checks done: %0d mismatches, %0d other errors", mismatch_cnt, fail_cnt);
    if (mismatch_cnt == 0 && fail_cnt == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    int n;
    n = 0;
    while (n < WATCHDOG) begin
      @(posedge clk);
      n++;
    end
    $display("Watchdog expired before the test sequence finished");
    $display("Simulation FAILED");
    $finish;
  end

endmodule

// File: verif/tb_clock_gen.sv
module tb_clock_gen #(
  parameter int PERIOD = 10
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever begin
      #(PERIOD / 2) clk = ~clk;
    end
  end

endmodule

// File: source/opb_dram_sniffer.sv
module opb_dram_sniffer
  import sniffer_cfg_pkg::*;
  import dram_cmd_pkg::*;
#(
  parameter logic [OPB_AW-1:0] CTRL_BASEADDR = 32'h8000_0000,
  parameter logic [OPB_AW-1:0] CTRL_HIGHADDR = 32'h8000_00FF,
  parameter logic [OPB_AW-1:0] MEM_BASEADDR  = 32'h9000_0000,
  parameter logic [OPB_AW-1:0] MEM_HIGHADDR  = 32'h93FF_FFFF,
  parameter int                RD_DEPTH      = 4
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                phy_ready,
  // Control OPB slave.
  input  logic [OPB_AW-1:0]   ctrl_opb_abus,
  input  logic [OPB_BEW-1:0]  ctrl_opb_be,
  input  logic [OPB_DW-1:0]   ctrl_opb_dbus,
  input  logic                ctrl_opb_rnw,
  input  logic                ctrl_opb_select,
  output logic [OPB_DW-1:0]   ctrl_sl_dbus,
  output logic                ctrl_sl_xferack,
  output logic                ctrl_sl_errack,
  // Memory window OPB slave.
  input  logic [OPB_AW-1:0]   mem_opb_abus,
  input  logic [OPB_BEW-1:0]  mem_opb_be,
  input  logic [OPB_DW-1:0]   mem_opb_dbus,
  input  logic                mem_opb_rnw,
  input  logic                mem_opb_select,
  output logic [OPB_DW-1:0]   mem_sl_dbus,
  output logic                mem_sl_xferack,
  // DRAM command port.
  output logic [DRAM_AW-1:0]  dram_cmd_addr,
  output logic                dram_cmd_rnw,
  output logic                dram_cmd_valid,
  output logic [DRAM_DW-1:0]  dram_wr_data,
  output logic [DRAM_BEW-1:0] dram_wr_be,
  input  logic [DRAM_DW-1:0]  dram_rd_data,
  input  logic                dram_rd_valid,
  input  logic                dram_fifo_ready,
  // Application client.
  input  logic [DRAM_AW-1:0]  app_cmd_addr,
  input  logic                app_cmd_rnw,
  input  logic                app_cmd_valid,
  output logic                app_cmd_ack,
  input  logic [DRAM_DW-1:0]  app_wr_data,
  input  logic [DRAM_BEW-1:0] app_wr_be,
  output logic [DRAM_DW-1:0]  app_rd_data,
  output logic                app_rd_valid
);

  logic [SW_ADDR_W-1:0] software_address_bits;

  dram_port_if app_port ();
  dram_port_if sniff_port ();

  assign app_port.cmd_addr  = app_cmd_addr << 2;  // Word to byte address.
  assign app_port.cmd_rnw   = app_cmd_rnw;
  assign app_port.cmd_valid = app_cmd_valid;
  assign app_port.wr_data   = app_wr_data;
  assign app_port.wr_be     = app_wr_be;
  assign app_cmd_ack        = app_port.ack;
  assign app_rd_data        = app_port.rd_data;
  assign app_rd_valid       = app_port.rd_valid;

  ctrl_opb_attach #(
    .CTRL_BASEADDR (CTRL_BASEADDR),
    .CTRL_HIGHADDR (CTRL_HIGHADDR)
  ) ctrl_opb_attach_i (
    .clk                   (clk),
    .rst_n                 (rst_n),
    .opb_abus              (ctrl_opb_abus),
    .opb_be                (ctrl_opb_be),
    .opb_dbus              (ctrl_opb_dbus),
    .opb_rnw               (ctrl_opb_rnw),
    .opb_select            (ctrl_opb_select),
    .phy_ready             (phy_ready),
    .sl_dbus               (ctrl_sl_dbus),
    .sl_xferack            (ctrl_sl_xferack),
    .sl_errack             (ctrl_sl_errack),
    .software_address_bits (software_address_bits)
  );

  mem_opb_attach #(
    .MEM_BASEADDR (MEM_BASEADDR),
    .MEM_HIGHADDR (MEM_HIGHADDR)
  ) mem_opb_attach_i (
    .clk                   (clk),
    .rst_n                 (rst_n),
    .opb_abus              (mem_opb_abus),
    .opb_be                (mem_opb_be),
    .opb_dbus              (mem_opb_dbus),
    .opb_rnw               (mem_opb_rnw),
    .opb_select            (mem_opb_select),
    .software_address_bits (software_address_bits),
    .sl_dbus               (mem_sl_dbus),
    .sl_xferack            (mem_sl_xferack),
    .dram                  (sniff_port.client)
  );

  dram_arbiter #(
    .RD_DEPTH (RD_DEPTH)
  ) dram_arbiter_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .app             (app_port.arbiter),
    .sniff           (sniff_port.arbiter),
    .dram_cmd_addr   (dram_cmd_addr),
    .dram_cmd_rnw    (dram_cmd_rnw),
    .dram_cmd_valid  (dram_cmd_valid),
    .dram_wr_data    (dram_wr_data),
    .dram_wr_be      (dram_wr_be),
    .dram_rd_data    (dram_rd_data),
    .dram_rd_valid   (dram_rd_valid),
    .dram_fifo_ready (dram_fifo_ready)
  );

endmodule

// File: source/dram_arbiter.sv
module dram_arbiter import dram_cmd_pkg::*; #(
  parameter int RD_DEPTH = 4
) (
  input  logic                clk,
  input  logic                rst_n,
  dram_port_if.arbiter        app,
  dram_port_if.arbiter        sniff,
  output logic [DRAM_AW-1:0]  dram_cmd_addr,
  output logic                dram_cmd_rnw,
  output logic                dram_cmd_valid,
  output logic [DRAM_DW-1:0]  dram_wr_data,
  output logic [DRAM_BEW-1:0] dram_wr_be,
  input  logic [DRAM_DW-1:0]  dram_rd_data,
  input  logic                dram_rd_valid,
  input  logic                dram_fifo_ready
);

  localparam int PTR_W = (RD_DEPTH > 1) ? $clog2(RD_DEPTH) : 1;
  localparam int CNT_W = $clog2(RD_DEPTH + 1);

  owner_t           q_mem [RD_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             q_full;
  logic             sel_app;
  logic             accept;
  logic             push;
  logic             pop;
  owner_t           head;

  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(RD_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  //////////////////////////////////////////////////
  // Command grant and forwarding
  //////////////////////////////////////////////////

  assign q_full  = (count == CNT_W'(RD_DEPTH));
  assign sel_app = app.cmd_valid;  // App always wins.

  assign dram_cmd_valid = (app.cmd_valid || sniff.cmd_valid) && !q_full;
  assign dram_cmd_addr  = sel_app ? app.cmd_addr : sniff.cmd_addr;
  assign dram_cmd_rnw   = sel_app ? app.cmd_rnw  : sniff.cmd_rnw;
  assign dram_wr_data   = sel_app ? app.wr_data  : sniff.wr_data;
  assign dram_wr_be     = sel_app ? app.wr_be    : sniff.wr_be;

  assign accept    = dram_cmd_valid && dram_fifo_ready;
  assign app.ack   = accept && sel_app;
  assign sniff.ack = accept && !sel_app;

  //////////////////////////////////////////////////
  // Read owner queue
  //////////////////////////////////////////////////

  assign push = accept && dram_cmd_rnw;
  assign pop  = dram_rd_valid && (count != '0);
  assign head = q_mem[rd_ptr];

  // Return goes to the owner at the head, same cycle.
  assign app.rd_valid   = pop && (head == OWNER_APP);
  assign sniff.rd_valid = pop && (head == OWNER_SNIFF);
  assign app.rd_data    = dram_rd_data;
  assign sniff.rd_data  = dram_rd_data;

  always_ff @(posedge clk) begin
    if (push) begin
      q_mem[wr_ptr] <= sel_app ? OWNER_APP : OWNER_SNIFF;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: source/mem_opb_attach.sv
module mem_opb_attach
  import sniffer_cfg_pkg::*;
  import dram_cmd_pkg::*;
#(
  parameter logic [OPB_AW-1:0] MEM_BASEADDR = 32'h9000_0000,
  parameter logic [OPB_AW-1:0] MEM_HIGHADDR = 32'h93FF_FFFF
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [OPB_AW-1:0]    opb_abus,
  input  logic [OPB_BEW-1:0]   opb_be,
  input  logic [OPB_DW-1:0]    opb_dbus,
  input  logic                 opb_rnw,
  input  logic                 opb_select,
  input  logic [SW_ADDR_W-1:0] software_address_bits,
  output logic [OPB_DW-1:0]    sl_dbus,
  output logic                 sl_xferack,
  dram_port_if.client          dram
);

  localparam int WORD_IDX_W = 22;
  localparam int SW_HI_W    = DRAM_AW - WORD_IDX_W - 2;  // Software bits used.

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_CMD,
    ST_WAIT_RD
  } state_t;

  state_t                state;
  logic [OPB_AW-1:0]     offset;
  logic [LANE_IDX_W-1:0] lane;
  logic [WORD_IDX_W-1:0] word_idx;
  logic                  hit;
  logic                  start;
  logic [DRAM_DW-1:0]    wr_data_d;
  logic [DRAM_BEW-1:0]   wr_be_d;

  // Command held for the arbiter.
  logic [DRAM_AW-1:0]    cmd_addr_q;
  logic                  rnw_q;
  logic [DRAM_DW-1:0]    wr_data_q;
  logic [DRAM_BEW-1:0]   wr_be_q;
  logic [LANE_IDX_W-1:0] lane_q;

  //////////////////////////////////////////////////
  // Window decode and lane placement
  //////////////////////////////////////////////////

  assign offset   = opb_abus - MEM_BASEADDR;
  assign lane     = offset[2 +: LANE_IDX_W];
  assign word_idx = offset[2 + LANE_IDX_W +: WORD_IDX_W];

  assign hit = opb_select && !sl_xferack &&
               (opb_abus >= MEM_BASEADDR) && (opb_abus <= MEM_HIGHADDR);
  assign start = (state == ST_IDLE) && hit;

  always_comb begin
    wr_data_d = '0;
    wr_be_d   = '0;
    wr_data_d[lane*LANE_DW +: LANE_DW]  = opb_dbus;
    wr_be_d[lane*LANE_BEW +: LANE_BEW]  = opb_be;  // Other lanes untouched.
  end

  always_ff @(posedge clk) begin
    if (start) begin
      cmd_addr_q <= {software_address_bits[SW_HI_W-1:0], word_idx, 2'b00};
      rnw_q      <= opb_rnw;
      wr_data_q  <= wr_data_d;
      wr_be_q    <= wr_be_d;
      lane_q     <= lane;
    end
  end

  assign dram.cmd_valid = (state == ST_CMD);
  assign dram.cmd_addr  = cmd_addr_q;
  assign dram.cmd_rnw   = rnw_q;
  assign dram.wr_data   = wr_data_q;
  assign dram.wr_be     = wr_be_q;

  //////////////////////////////////////////////////
  // Access FSM
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= ST_IDLE;
      sl_xferack <= 1'b0;
      sl_dbus    <= '0;
    end else begin
      sl_xferack <= 1'b0;
      sl_dbus    <= '0;
      case (state)
        ST_IDLE: begin
          if (start) begin
            state <= ST_CMD;
          end
        end
        ST_CMD: begin
          if (dram.ack) begin
            if (rnw_q) begin
              state <= ST_WAIT_RD;
            end else begin
              sl_xferack <= 1'b1;  // Write done once taken.
              state      <= ST_IDLE;
            end
          end
        end
        ST_WAIT_RD: begin
          if (dram.rd_valid) begin
            sl_xferack <= 1'b1;
            sl_dbus    <= dram.rd_data[lane_q*LANE_DW +: LANE_DW];
            state      <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

// File: source/ctrl_opb_attach.sv
module ctrl_opb_attach import sniffer_cfg_pkg::*; #(
  parameter logic [OPB_AW-1:0] CTRL_BASEADDR = 32'h8000_0000,
  parameter logic [OPB_AW-1:0] CTRL_HIGHADDR = 32'h8000_00FF
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [OPB_AW-1:0]    opb_abus,
  input  logic [OPB_BEW-1:0]   opb_be,
  input  logic [OPB_DW-1:0]    opb_dbus,
  input  logic                 opb_rnw,
  input  logic                 opb_select,
  input  logic                 phy_ready,
  output logic [OPB_DW-1:0]    sl_dbus,
  output logic                 sl_xferack,
  output logic                 sl_errack,
  output logic [SW_ADDR_W-1:0] software_address_bits
);

  logic [OPB_AW-1:0] offset;
  logic [OPB_AW-1:0] reg_off;
  logic              hit;
  logic              is_swaddr;
  logic              is_status;
  logic              mapped;
  logic [OPB_DW-1:0] rd_word;

  //////////////////////////////////////////////////
  // Address decode
  //////////////////////////////////////////////////

  assign offset  = opb_abus - CTRL_BASEADDR;
  assign reg_off = {offset[OPB_AW-1:2], 2'b00};  // Word aligned.

  // Skip the ack cycle while the master still holds select.
  assign hit = opb_select && !sl_xferack && !sl_errack &&
               (opb_abus >= CTRL_BASEADDR) && (opb_abus <= CTRL_HIGHADDR);

  assign is_swaddr = (reg_off == CTRL_REG_SWADDR);
  assign is_status = (reg_off == CTRL_REG_STATUS);
  assign mapped    = is_swaddr || is_status;

  always_comb begin
    rd_word = '0;
    if (is_swaddr) begin
      rd_word[SW_ADDR_W-1:0] = software_address_bits;
    end
    if (is_status) begin
      rd_word[STATUS_PHY_READY_BIT] = phy_ready;
    end
  end

  //////////////////////////////////////////////////
  // Acknowledge and register update
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sl_xferack            <= 1'b0;
      sl_errack             <= 1'b0;
      sl_dbus               <= '0;
      software_address_bits <= '0;
    end else begin
      sl_xferack <= hit && mapped;
      sl_errack  <= hit && !mapped;
      sl_dbus    <= (hit && opb_rnw) ? rd_word : '0;  // Zero outside read ack.
      if (hit && !opb_rnw && is_swaddr) begin
        for (int b = 0; b < SW_ADDR_W / 8; b++) begin
          if (opb_be[b]) begin
            software_address_bits[b*8 +: 8] <= opb_dbus[b*8 +: 8];
          end
        end
      end
    end
  end

endmodule

// File: source/dram_port_if.sv
interface dram_port_if import dram_cmd_pkg::*; ();

  // Command side, driven by the client.
  logic [DRAM_AW-1:0]  cmd_addr;
  logic                cmd_rnw;
  logic                cmd_valid;
  logic [DRAM_DW-1:0]  wr_data;
  logic [DRAM_BEW-1:0] wr_be;

  // Response side, driven by the arbiter.
  logic                ack;       // Command taken when high with cmd_valid.
  logic [DRAM_DW-1:0]  rd_data;
  logic                rd_valid;  // One pulse per read, in order.

  modport client (
    output cmd_addr,
    output cmd_rnw,
    output cmd_valid,
    output wr_data,
    output wr_be,
    input  ack,
    input  rd_data,
    input  rd_valid
  );

  modport arbiter (
    input  cmd_addr,
    input  cmd_rnw,
    input  cmd_valid,
    input  wr_data,
    input  wr_be,
    output ack,
    output rd_data,
    output rd_valid
  );

endinterface

// File: source/dram_cmd_pkg.sv
package dram_cmd_pkg;

  //////////////////////////////////////////////////
  // DRAM command port widths
  //////////////////////////////////////////////////

  localparam int DRAM_AW  = 32;
  localparam int DRAM_DW  = 128;
  localparam int DRAM_BEW = DRAM_DW / 8;  // 16 byte enables.

  //////////////////////////////////////////////////
  // 32-bit lanes inside one DRAM word
  //////////////////////////////////////////////////

  localparam int LANES      = 4;
  localparam int LANE_DW    = DRAM_DW / LANES;
  localparam int LANE_BEW   = DRAM_BEW / LANES;
  localparam int LANE_IDX_W = $clog2(LANES);

  //////////////////////////////////////////////////
  // Read ownership
  //////////////////////////////////////////////////

  // Tags each read in flight with the client that issued it.
  typedef enum logic {
    OWNER_APP   = 1'b0,
    OWNER_SNIFF = 1'b1
  } owner_t;

endpackage

// File: source/sniffer_cfg_pkg.sv
package sniffer_cfg_pkg;

  //////////////////////////////////////////////////
  // OPB bus widths
  //////////////////////////////////////////////////

  localparam int OPB_AW  = 32;
  localparam int OPB_DW  = 32;
  localparam int OPB_BEW = OPB_DW / 8;  // One enable per byte.

  //////////////////////////////////////////////////
  // Control window register map
  //////////////////////////////////////////////////

  // Offsets from the control base address.
  localparam logic [OPB_AW-1:0] CTRL_REG_SWADDR = 32'h0000_0000;
  localparam logic [OPB_AW-1:0] CTRL_REG_STATUS = 32'h0000_0004;

  // Status register bit holding the PHY ready flag.
  localparam int STATUS_PHY_READY_BIT = 0;

  //////////////////////////////////////////////////
  // Software address register
  //////////////////////////////////////////////////

  // Upper DRAM address bits written by the host.
  localparam int SW_ADDR_W = 16;

endpackage
